// ==== core_consts.svh ====
/*
 * core constants
 * bridge register map, field widths, reset stretch length and
 * video status word layout for the console core top level
 */

`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// bridge register map, word addresses
`define CORE_ADDR_RESET          32'h0000_0050
`define CORE_ADDR_HIDE_OVERSCAN  32'h0000_0200
`define CORE_ADDR_MASK_EDGES     32'h0000_0204
`define CORE_ADDR_EXTRA_SPRITES  32'h0000_0208
`define CORE_ADDR_PALETTE        32'h0000_020C
`define CORE_ADDR_VIDEO_4_3      32'h0000_0210
`define CORE_ADDR_MULTITAP       32'h0000_0300
`define CORE_ADDR_LIGHTGUN       32'h0000_0304
`define CORE_ADDR_AIM_SPEED      32'h0000_0308
`define CORE_ADDR_SWAP_CONT      32'h0000_030C

// option field widths
`define CORE_EDGE_MASK_W         2
`define CORE_PALETTE_W           3
`define CORE_AIM_SPEED_W         8
`define CORE_RGB_W               24

// core reset stays high this many cycles after a reset write
`define CORE_RESET_CYCLES        32'h0010_0000

// hsync pulse reload, lands 7 cycles behind the raw edge
`define CORE_HS_DELAY            3'd7

// status word bits shown on the first blank pixel of a line
`define CORE_SLOT_BIT_4_3        14
`define CORE_SLOT_BIT_OVERSCAN   13

`endif

// ==== core_pkg.sv ====
/*
 * core package
 * register select enum and the field types shared by the
 * settings block, the video path and the top level
 */

`include "core_consts.svh"

package core_pkg;

  // which option register a bridge write address points at
  typedef enum logic [3:0] {
    SEL_NONE,
    SEL_RESET,
    SEL_HIDE_OVERSCAN,
    SEL_MASK_EDGES,
    SEL_EXTRA_SPRITES,
    SEL_PALETTE,
    SEL_VIDEO_4_3,
    SEL_MULTITAP,
    SEL_LIGHTGUN,
    SEL_AIM_SPEED,
    SEL_SWAP_CONT
  } setting_sel_e;

  // palette index
  typedef logic [`CORE_PALETTE_W-1:0] palette_t;

  // edge masking mode
  typedef logic [`CORE_EDGE_MASK_W-1:0] edge_mask_t;

  // pixel colour, red in [23:16], green in [15:8], blue in [7:0]
  typedef logic [`CORE_RGB_W-1:0] rgb_t;

endpackage

// ==== core_ifs.sv ====
/*
 * core interfaces
 * option register bundle written by the bridge block, and the raw
 * video bundle coming out of the emulated console
 */

`include "core_consts.svh"

interface core_settings_if import core_pkg::*; ();

  logic                         hide_overscan;
  edge_mask_t                   mask_vid_edges;
  logic                         allow_extra_sprites;
  palette_t                     selected_palette;
  logic                         use_4_3_video;
  logic                         multitap_enabled;
  logic                         lightgun_enabled;
  logic [`CORE_AIM_SPEED_W-1:0] lightgun_dpad_aim_speed;
  logic                         swap_controllers;

  // register block side
  modport owner (
    output hide_overscan, mask_vid_edges, allow_extra_sprites, selected_palette,
    output use_4_3_video, multitap_enabled, lightgun_enabled,
    output lightgun_dpad_aim_speed, swap_controllers
  );

  // consumers of the options
  modport reader (
    input hide_overscan, mask_vid_edges, allow_extra_sprites, selected_palette,
    input use_4_3_video, multitap_enabled, lightgun_enabled,
    input lightgun_dpad_aim_speed, swap_controllers
  );

endinterface

interface core_video_if import core_pkg::*; ();

  logic h_blank;
  logic v_blank;
  logic hsync;
  logic vsync;
  rgb_t rgb;

  modport source (output h_blank, v_blank, hsync, vsync, rgb);
  modport sink   (input  h_blank, v_blank, hsync, vsync, rgb);

endinterface

// ==== bridge_settings.sv ====
/*
 * bridge settings
 * decodes single-cycle bridge writes into the core option registers
 * and stretches a reset write into a long core reset
 */

`include "core_consts.svh"

module bridge_settings import core_pkg::*; (
  input  logic           clk_74a,
  input  logic           pll_core_locked,
  input  logic [31:0]    bridge_addr,
  input  logic           bridge_wr,
  input  logic [31:0]    bridge_wr_data,
  core_settings_if.owner settings,
  output logic           core_reset
);

  setting_sel_e sel;
  logic [31:0]  reset_count;

  ////////////////////////////////////////
  // address decode

  always_comb begin
    case (bridge_addr)
      `CORE_ADDR_RESET:         sel = SEL_RESET;
      `CORE_ADDR_HIDE_OVERSCAN: sel = SEL_HIDE_OVERSCAN;
      `CORE_ADDR_MASK_EDGES:    sel = SEL_MASK_EDGES;
      `CORE_ADDR_EXTRA_SPRITES: sel = SEL_EXTRA_SPRITES;
      `CORE_ADDR_PALETTE:       sel = SEL_PALETTE;
      `CORE_ADDR_VIDEO_4_3:     sel = SEL_VIDEO_4_3;
      `CORE_ADDR_MULTITAP:      sel = SEL_MULTITAP;
      `CORE_ADDR_LIGHTGUN:      sel = SEL_LIGHTGUN;
      `CORE_ADDR_AIM_SPEED:     sel = SEL_AIM_SPEED;
      `CORE_ADDR_SWAP_CONT:     sel = SEL_SWAP_CONT;
      default:                  sel = SEL_NONE;
    endcase
  end

  ////////////////////////////////////////
  // option registers

  // each register keeps only its own low field of the write data
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings.hide_overscan           <= 1'b0;
      settings.mask_vid_edges          <= '0;
      settings.allow_extra_sprites     <= 1'b0;
      settings.selected_palette        <= '0;
      settings.use_4_3_video           <= 1'b0;
      settings.multitap_enabled        <= 1'b0;
      settings.lightgun_enabled        <= 1'b0;
      settings.lightgun_dpad_aim_speed <= '0;
      settings.swap_controllers        <= 1'b0;
    end else if (bridge_wr) begin
      case (sel)
        SEL_HIDE_OVERSCAN: settings.hide_overscan <= bridge_wr_data[0];
        SEL_MASK_EDGES:
          settings.mask_vid_edges <= bridge_wr_data[`CORE_EDGE_MASK_W-1:0];
        SEL_EXTRA_SPRITES: settings.allow_extra_sprites <= bridge_wr_data[0];
        SEL_PALETTE:
          settings.selected_palette <= bridge_wr_data[`CORE_PALETTE_W-1:0];
        SEL_VIDEO_4_3:     settings.use_4_3_video <= bridge_wr_data[0];
        SEL_MULTITAP:      settings.multitap_enabled <= bridge_wr_data[0];
        SEL_LIGHTGUN:      settings.lightgun_enabled <= bridge_wr_data[0];
        SEL_AIM_SPEED:
          settings.lightgun_dpad_aim_speed <= bridge_wr_data[`CORE_AIM_SPEED_W-1:0];
        SEL_SWAP_CONT:     settings.swap_controllers <= bridge_wr_data[0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////
  // reset countdown

  // a reset write reloads the count, also in the middle of a countdown
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      reset_count <= '0;
    end else if (bridge_wr && sel == SEL_RESET) begin
      reset_count <= `CORE_RESET_CYCLES;
    end else if (reset_count != '0) begin
      reset_count <= reset_count - 32'd1;
    end
  end

  // high from the write edge for exactly CORE_RESET_CYCLES cycles
  assign core_reset = (reset_count != '0);

endmodule

// ==== video_sync_shaper.sv ====
/*
 * video sync shaper
 * turns raw hsync and vsync levels into single-cycle pulses,
 * with hsync pushed behind its edge to keep clear of vsync
 */

`include "core_consts.svh"

module video_sync_shaper (
  input  logic        clk_74a,
  input  logic        pll_core_locked,
  core_video_if.sink  raw,
  output logic        video_hs,
  output logic        video_vs
);

  logic       hs_prev;
  logic       vs_prev;
  logic [2:0] hs_delay;
  logic       hs_rise;
  logic       vs_rise;

  // rising edges of the raw syncs
  assign hs_rise = raw.hsync & ~hs_prev;
  assign vs_rise = raw.vsync & ~vs_prev;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_prev <= 1'b0;
      vs_prev <= 1'b0;
    end else begin
      hs_prev <= raw.hsync;
      vs_prev <= raw.vsync;
    end
  end

  ////////////////////////////////////////
  // horizontal pulse

  // reload on each edge, pulse fires as the count passes 1
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_delay <= '0;
      video_hs <= 1'b0;
    end else begin
      video_hs <= (hs_delay == 3'd1);
      if (hs_rise) begin
        hs_delay <= `CORE_HS_DELAY;
      end else if (hs_delay != '0) begin
        hs_delay <= hs_delay - 3'd1;
      end
    end
  end

  ////////////////////////////////////////
  // vertical pulse, right on the edge

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_vs <= 1'b0;
    end else begin
      video_vs <= vs_rise;
    end
  end

endmodule

// ==== video_pixel_path.sv ====
/*
 * video pixel path
 * registers data-enable and colour for the scaler and puts the
 * status word on the first blank pixel after each active stretch
 */

`include "core_consts.svh"

module video_pixel_path import core_pkg::*; (
  input  logic            clk_74a,
  input  logic            pll_core_locked,
  core_video_if.sink      raw,
  core_settings_if.reader settings,
  output logic            video_de,
  output rgb_t            video_rgb
);

  logic de;
  logic de_prev;
  rgb_t slot_word;
  rgb_t rgb_next;

  // active pixel when neither blank is set
  assign de = ~(raw.h_blank | raw.v_blank);

  // status word, only the two video flags are set
  always_comb begin
    slot_word                          = '0;
    slot_word[`CORE_SLOT_BIT_4_3]      = settings.use_4_3_video;
    slot_word[`CORE_SLOT_BIT_OVERSCAN] = settings.hide_overscan;
  end

  // pixel, then status word on the falling de edge, else black
  always_comb begin
    if (de) begin
      rgb_next = raw.rgb;
    end else if (de_prev) begin
      rgb_next = slot_word;
    end else begin
      rgb_next = '0;
    end
  end

  ////////////////////////////////////////
  // output registers

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      de_prev   <= 1'b0;
      video_de  <= 1'b0;
      video_rgb <= '0;
    end else begin
      de_prev   <= de;
      video_de  <= de;
      video_rgb <= rgb_next;
    end
  end

endmodule

// ==== core_top.sv ====
/*
 * core top level
 * bridge option registers, core reset stretch and scaler video
 * output, all running on the 74.25 MHz bridge clock
 */

`include "core_consts.svh"

module core_top import core_pkg::*; (
  input  logic                         clk_74a,
  input  logic                         pll_core_locked,

  // bridge bus, writes only
  input  logic [31:0]                  bridge_addr,
  input  logic                         bridge_wr,
  input  logic [31:0]                  bridge_wr_data,

  // raw video from the console
  input  logic                         h_blank,
  input  logic                         v_blank,
  input  logic                         hsync_in,
  input  logic                         vsync_in,
  input  rgb_t                         rgb_in,

  // scaler video
  output logic                         video_de,
  output logic                         video_hs,
  output logic                         video_vs,
  output rgb_t                         video_rgb,

  // to the console core
  output logic                         core_reset,
  output logic                         hide_overscan,
  output edge_mask_t                   mask_vid_edges,
  output logic                         allow_extra_sprites,
  output palette_t                     selected_palette,
  output logic                         use_4_3_video,
  output logic                         multitap_enabled,
  output logic                         lightgun_enabled,
  output logic [`CORE_AIM_SPEED_W-1:0] lightgun_dpad_aim_speed,
  output logic                         swap_controllers
);

  core_settings_if settings_if ();
  core_video_if    raw_video ();

  ////////////////////////////////////////
  // raw video in

  assign raw_video.h_blank = h_blank;
  assign raw_video.v_blank = v_blank;
  assign raw_video.hsync   = hsync_in;
  assign raw_video.vsync   = vsync_in;
  assign raw_video.rgb     = rgb_in;

  ////////////////////////////////////////
  // options out to the core

  assign hide_overscan           = settings_if.hide_overscan;
  assign mask_vid_edges          = settings_if.mask_vid_edges;
  assign allow_extra_sprites     = settings_if.allow_extra_sprites;
  assign selected_palette        = settings_if.selected_palette;
  assign use_4_3_video           = settings_if.use_4_3_video;
  assign multitap_enabled        = settings_if.multitap_enabled;
  assign lightgun_enabled        = settings_if.lightgun_enabled;
  assign lightgun_dpad_aim_speed = settings_if.lightgun_dpad_aim_speed;
  assign swap_controllers        = settings_if.swap_controllers;

  ////////////////////////////////////////
  // blocks

  bridge_settings u_bridge_settings (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .settings        (settings_if.owner),
    .core_reset      (core_reset)
  );

  video_sync_shaper u_video_sync_shaper (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .raw             (raw_video.sink),
    .video_hs        (video_hs),
    .video_vs        (video_vs)
  );

  video_pixel_path u_video_pixel_path (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .raw             (raw_video.sink),
    .settings        (settings_if.reader),
    .video_de        (video_de),
    .video_rgb       (video_rgb)
  );

endmodule

// ==== tb_core_top.sv ====
/*
 * core top testbench
 * drives bridge writes and raw video into core_top and checks
 * every output on each clock against a reference model
 */

`include "core_consts.svh"

module tb_core_top import core_pkg::*; ();

  localparam longint RUN_CYCLES = longint'(`CORE_RESET_CYCLES) + 5000;

  logic        clk_74a, pll_core_locked;
  logic [31:0] bridge_addr, bridge_wr_data;
  logic        bridge_wr;
  logic        h_blank, v_blank, hsync_in, vsync_in;
  rgb_t        rgb_in, video_rgb;
  logic        video_de, video_hs, video_vs, core_reset;
  logic        hide_overscan, allow_extra_sprites, use_4_3_video;
  logic        multitap_enabled, lightgun_enabled, swap_controllers;
  edge_mask_t  mask_vid_edges;
  palette_t    selected_palette;
  logic [7:0]  lightgun_dpad_aim_speed;

  // shadow option registers and reset count
  logic        m_hide, m_extra, m_43, m_multi, m_gun, m_swap;
  logic [1:0]  m_mask;
  logic [2:0]  m_pal;
  logic [7:0]  m_aim;
  logic [31:0] m_reset_cnt;
  // raw levels at the previous edge
  logic        m_hb_prev, m_vb_prev, m_hs_prev, m_vs_prev;
  // edges since the latest hsync rise
  int          m_hs_age;
  logic [24:0] e_video;
  logic        e_hs, e_vs;
  logic [31:0] opt_addrs [0:8];
  integer      seed;
  int          errors, checks, tests;

  core_top uut (.*);

  initial begin
    clk_74a = 1'b0;
    forever #10 clk_74a = ~clk_74a;
  end

  // stops a hung run
  initial begin
    #(2 * RUN_CYCLES * 20);
    $display("timeout: tests did not finish within %0d cycles", 2 * RUN_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // reference model

  // expected {de, rgb} after an edge
  function automatic logic [24:0] ref_video(input logic hb_prev, input logic vb_prev,
                                            input logic hb, input logic vb, input rgb_t rgb,
                                            input logic use_4_3, input logic hide_os);
    logic de_now;
    logic de_was;
    rgb_t status;
    de_now = !(hb || vb);
    de_was = !(hb_prev || vb_prev);
    status = '0;
    status[`CORE_SLOT_BIT_4_3] = use_4_3;
    status[`CORE_SLOT_BIT_OVERSCAN] = hide_os;
    if (de_now) begin
      return {1'b1, rgb};
    end else if (de_was) begin
      return {1'b0, status};
    end
    return 25'h0;
  endfunction

  task automatic reset_model();
    {m_hide, m_extra, m_43, m_multi, m_gun, m_swap, m_mask, m_pal, m_aim} = '0;
    {m_reset_cnt, m_hs_prev, m_vs_prev} = '0;
    // no hsync rise seen yet
    m_hs_age = 16;
    // nothing active before reset
    {m_hb_prev, m_vb_prev} = 2'b11;
    {e_video, e_hs, e_vs} = '0;
  endtask

  task automatic apply_write(input logic [31:0] addr, input logic [31:0] data);
    case (addr)
      `CORE_ADDR_RESET:         m_reset_cnt = `CORE_RESET_CYCLES;
      `CORE_ADDR_HIDE_OVERSCAN: m_hide = data[0];
      `CORE_ADDR_MASK_EDGES:    m_mask = data[1:0];
      `CORE_ADDR_EXTRA_SPRITES: m_extra = data[0];
      `CORE_ADDR_PALETTE:       m_pal = data[2:0];
      `CORE_ADDR_VIDEO_4_3:     m_43 = data[0];
      `CORE_ADDR_MULTITAP:      m_multi = data[0];
      `CORE_ADDR_LIGHTGUN:      m_gun = data[0];
      `CORE_ADDR_AIM_SPEED:     m_aim = data[7:0];
      `CORE_ADDR_SWAP_CONT:     m_swap = data[0];
      default: ;
    endcase
  endtask

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] got_v);
    checks++;
    assert (got_v === exp_v) else begin
      $display("Error: %s expected 0x%h got 0x%h at %0t", name, exp_v, got_v, $time);
      errors++;
    end
  endtask

  // inputs sampled at the edge are still held and outputs have settled
  always @(posedge clk_74a) begin
    #1;
    if (!pll_core_locked) begin
      reset_model();
    end else begin
      e_video = ref_video(m_hb_prev, m_vb_prev, h_blank, v_blank, rgb_in, m_43, m_hide);
      e_vs = vsync_in && !m_vs_prev;
      // pulse on the edge that lies CORE_HS_DELAY edges after the latest rise
      if (m_hs_age < 16) begin
        m_hs_age++;
      end
      e_hs = (m_hs_age == int'(`CORE_HS_DELAY));
      if (hsync_in && !m_hs_prev) begin
        m_hs_age = 0;
      end
      {m_hb_prev, m_vb_prev, m_hs_prev, m_vs_prev} = {h_blank, v_blank, hsync_in, vsync_in};
      if (m_reset_cnt != 32'd0) begin
        m_reset_cnt = m_reset_cnt - 32'd1;
      end
      if (bridge_wr) begin
        apply_write(bridge_addr, bridge_wr_data);
      end
    end
    check_val("video_de", 32'(e_video[24]), 32'(video_de));
    check_val("video_rgb", 32'(e_video[23:0]), 32'(video_rgb));
    check_val("video_hs", 32'(e_hs), 32'(video_hs));
    check_val("video_vs", 32'(e_vs), 32'(video_vs));
    check_val("core_reset", 32'(m_reset_cnt != 32'd0), 32'(core_reset));
    check_val("hide_overscan", 32'(m_hide), 32'(hide_overscan));
    check_val("mask_vid_edges", 32'(m_mask), 32'(mask_vid_edges));
    check_val("allow_extra_sprites", 32'(m_extra), 32'(allow_extra_sprites));
    check_val("selected_palette", 32'(m_pal), 32'(selected_palette));
    check_val("use_4_3_video", 32'(m_43), 32'(use_4_3_video));
    check_val("multitap_enabled", 32'(m_multi), 32'(multitap_enabled));
    check_val("lightgun_enabled", 32'(m_gun), 32'(lightgun_enabled));
    check_val("lightgun_dpad_aim_speed", 32'(m_aim), 32'(lightgun_dpad_aim_speed));
    check_val("swap_controllers", 32'(m_swap), 32'(swap_controllers));
  end

  ////////////////////////////////////////
  // stimulus helpers

  task automatic drive_write(input logic [31:0] addr, input logic [31:0] data);
    @(negedge clk_74a);
    bridge_wr      = 1'b1;
    bridge_addr    = addr;
    bridge_wr_data = data;
    @(negedge clk_74a);
    bridge_wr      = 1'b0;
  endtask

  // falling edges from the hsync rise until video_hs shows
  task automatic measure_hs(output int cycles);
    cycles = 0;
    do begin
      @(negedge clk_74a);
      cycles++;
    end while (!video_hs && cycles < 32);
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests++;
    if (errors == err_start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - err_start);
    end
  endtask

  ////////////////////////////////////////
  // tests

  initial begin
    int          err_start;
    int          idx;
    int          falls;
    int          n;
    logic        de_last;
    logic [31:0] high_cycles;
    seed = 23;
    errors = 0;
    checks = 0;
    tests = 0;
    opt_addrs = '{`CORE_ADDR_HIDE_OVERSCAN, `CORE_ADDR_MASK_EDGES, `CORE_ADDR_EXTRA_SPRITES,
                  `CORE_ADDR_PALETTE, `CORE_ADDR_VIDEO_4_3, `CORE_ADDR_MULTITAP,
                  `CORE_ADDR_LIGHTGUN, `CORE_ADDR_AIM_SPEED, `CORE_ADDR_SWAP_CONT};
    pll_core_locked = 1'b0;
    {bridge_addr, bridge_wr, bridge_wr_data, hsync_in, vsync_in, rgb_in} = '0;
    {h_blank, v_blank} = 2'b11;
    repeat (3) @(posedge clk_74a);
    @(negedge clk_74a);
    pll_core_locked = 1'b1;

    err_start = errors;
    @(negedge clk_74a);
    assert ({video_de, video_hs, video_vs, video_rgb, core_reset, hide_overscan,
             mask_vid_edges, allow_extra_sprites, selected_palette, use_4_3_video,
             multitap_enabled, lightgun_enabled, lightgun_dpad_aim_speed,
             swap_controllers} == '0) else begin
      $display("outputs are not all zero after reset");
      errors++;
    end
    finish_test("reset values", err_start);

    // odd addresses never hit a register
    err_start = errors;
    repeat (200) begin
      idx = int'($unsigned($random(seed)) % 10);
      if (idx < 9) begin
        drive_write(opt_addrs[idx], $random(seed));
      end else begin
        drive_write(32'($random(seed)) | 32'd1, $random(seed));
      end
    end
    finish_test("register writes", err_start);

    err_start = errors;
    drive_write(`CORE_ADDR_RESET, $random(seed));
    repeat (100) @(negedge clk_74a);
    assert (core_reset) else begin
      $display("core_reset dropped during the countdown");
      errors++;
    end
    drive_write(`CORE_ADDR_RESET, $random(seed));
    high_cycles = 32'd0;
    while (core_reset && high_cycles < `CORE_RESET_CYCLES + 32'd16) begin
      high_cycles++;
      @(negedge clk_74a);
    end
    check_val("core_reset high cycles", `CORE_RESET_CYCLES, high_cycles);
    finish_test("reset countdown", err_start);

    err_start = errors;
    for (int combo = 0; combo < 4; combo++) begin
      drive_write(`CORE_ADDR_VIDEO_4_3, {31'($random(seed)), combo[1]});
      drive_write(`CORE_ADDR_HIDE_OVERSCAN, {31'($random(seed)), combo[0]});
      falls = 0;
      de_last = !(h_blank || v_blank);
      repeat (300) begin
        @(negedge clk_74a);
        if (($random(seed) & 7) == 0) begin
          h_blank = ~h_blank;
        end
        v_blank = (($random(seed) & 63) == 0);
        rgb_in = 24'($random(seed));
        if (de_last && (h_blank || v_blank)) begin
          falls++;
        end
        de_last = !(h_blank || v_blank);
      end
      assert (falls > 0) else begin
        $display("no active stretch ended for option combination %0d", combo);
        errors++;
      end
    end
    finish_test("pixel path", err_start);

    err_start = errors;
    @(negedge clk_74a);
    hsync_in = 1'b1;
    measure_hs(n);
    check_val("hsync delay", `CORE_HS_DELAY + 1, n);
    hsync_in = 1'b0;
    // second rise lands before the first pulse
    @(negedge clk_74a);
    hsync_in = 1'b1;
    @(negedge clk_74a);
    hsync_in = 1'b0;
    @(negedge clk_74a);
    hsync_in = 1'b1;
    measure_hs(n);
    check_val("hsync retrigger delay", `CORE_HS_DELAY + 1, n);
    hsync_in = 1'b0;
    @(negedge clk_74a);
    vsync_in = 1'b1;
    @(negedge clk_74a);
    assert (video_vs) else begin
      $display("video_vs missing after the vsync rise");
      errors++;
    end
    @(negedge clk_74a);
    assert (!video_vs) else begin
      $display("video_vs longer than one cycle");
      errors++;
    end
    vsync_in = 1'b0;
    repeat (400) begin
      @(negedge clk_74a);
      if (($random(seed) & 3) == 0) begin
        hsync_in = ~hsync_in;
      end
      if (($random(seed) & 15) == 0) begin
        vsync_in = ~vsync_in;
      end
    end
    finish_test("sync pulses", err_start);

    repeat (2) @(negedge clk_74a);
    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== core_top.f ====
+incdir+.
core_pkg.sv
core_ifs.sv
bridge_settings.sv
video_sync_shaper.sv
video_pixel_path.sv
core_top.sv
tb_core_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the core_top testbench with Verilator and run it
# the run fails when the log holds the fail status line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_core_top -f core_top.f \
  > build.log 2>&1 &&
  ./obj_dir/Vtb_core_top > sim.log 2>&1 ||
  { echo "build or run error, see build.log and sim.log"; exit 1; }

grep -q "STATUS: FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "no status line in sim.log"; exit 1; }
echo "simulation passed"
